// File: source/grant_line_buffer.sv
// Beats may arrive with gaps but the refill ends on beat index 3; grants are always accepted
`include "refill_defines.svh"

module grant_line_buffer (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Grant channel from L2
    input  logic                   grant_valid_i,
    input  refill_pkg::beat_idx_t  grant_beat_i,
    input  refill_pkg::beat_data_t grant_data_i,

    // PMU event sampled with the last beat only
    input  logic                   l2_hit_i,

    // Finished line towards the fill writer
    output logic                   line_done_o,
    output refill_pkg::line_t      line_data_o,
    output logic                   line_l2_hit_o
);

    import refill_pkg::*;

    // ------------------------------
    // Line assembly
    // ------------------------------

    // Line under construction
    line_t line_q;

    // Registered completion pulse
    logic  done_q;

    // Hit flag of the completed refill
    logic  hit_q;

    // Acknowledge beat
    logic  last_beat;

    // Both index bits set marks the final beat of the line
    assign last_beat = grant_valid_i && (&grant_beat_i);

    // Each valid beat goes into its own 128-bit slot
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < `REFILL_BEATS; k++) begin
            if (grant_valid_i && (grant_beat_i == beat_idx_t'(k))) begin
                line_q[k*`REFILL_BEAT_W +: `REFILL_BEAT_W] <= grant_data_i;
            end
        end
    end

    // ------------------------------
    // Completion
    // ------------------------------

    // Pulse one cycle after the last beat
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_q <= 1'b0;
            hit_q  <= 1'b0;
        end else begin
            done_q <= last_beat;
            // Sample the L2 hit only with the acknowledge beat
            if (last_beat) begin
                hit_q <= l2_hit_i;
            end
        end
    end

    // Outputs
    assign line_done_o   = done_q;
    assign line_data_o   = line_q;
    assign line_l2_hit_o = hit_q;

endmodule

// File: source/icache_refill_tile.sv
// Icache refill path only; constant acquire fields and grant ready are not brought out
module icache_refill_tile (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Miss side
    input  logic                    miss_valid_i,
    input  refill_pkg::block_addr_t miss_block_addr_i,

    // L2 grant
    input  logic                    grant_valid_i,
    input  refill_pkg::beat_idx_t   grant_beat_i,
    input  refill_pkg::beat_data_t  grant_data_i,
    input  logic                    l2_hit_i,

    // L2 acquire
    output logic                    acquire_valid_o,
    output refill_pkg::block_addr_t acquire_block_addr_o,
    output logic                    miss_busy_o,

    // Cache fill
    output logic                    fill_valid_o,
    output refill_pkg::block_addr_t fill_block_addr_o,
    output refill_pkg::line_t       fill_line_o,

    // PMU
    output refill_pkg::pmu_cnt_t    refill_count_o,
    output refill_pkg::pmu_cnt_t    l2_hit_count_o
);

    import refill_pkg::*;

    // Buffer to requester and writer
    logic  line_done;
    line_t line_data;
    logic  line_l2_hit;

    // ------------------------------
    // Acquire side
    // ------------------------------

    refill_requester u_requester (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .miss_valid_i         (miss_valid_i),
        .miss_block_addr_i    (miss_block_addr_i),
        .line_done_i          (line_done),
        .acquire_valid_o      (acquire_valid_o),
        .acquire_block_addr_o (acquire_block_addr_o),
        .miss_busy_o          (miss_busy_o)
    );

    // Grant beats into a line
    grant_line_buffer u_line_buffer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .grant_valid_i (grant_valid_i),
        .grant_beat_i  (grant_beat_i),
        .grant_data_i  (grant_data_i),
        .l2_hit_i      (l2_hit_i),
        .line_done_o   (line_done),
        .line_data_o   (line_data),
        .line_l2_hit_o (line_l2_hit)
    );

    // Fill port and counters
    // Address comes from the requester's held acquire address
    refill_fill_writer u_fill_writer (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .line_done_i       (line_done),
        .line_data_i       (line_data),
        .line_l2_hit_i     (line_l2_hit),
        .block_addr_i      (acquire_block_addr_o),
        .fill_valid_o      (fill_valid_o),
        .fill_block_addr_o (fill_block_addr_o),
        .fill_line_o       (fill_line_o),
        .refill_count_o    (refill_count_o),
        .l2_hit_count_o    (l2_hit_count_o)
    );

endmodule

// File: source/refill_defines.svh
// Refill geometry macros; the line width must stay the beat width times the beat count
`ifndef REFILL_DEFINES_SVH
`define REFILL_DEFINES_SVH

// ------------------------------
// Address side
// ------------------------------

// Cache-block address as sent on the acquire
`define REFILL_BLOCK_ADDR_W 26

// ------------------------------
// Grant data side
// ------------------------------

// One L2 grant beat
`define REFILL_BEAT_W 128

// Beats per cache line
`define REFILL_BEATS 4

// Beat index carried with every grant
`define REFILL_BEAT_IDX_W 2

// Assembled line of four 128-bit beats
`define REFILL_LINE_W (`REFILL_BEAT_W * `REFILL_BEATS)

// ------------------------------
// PMU
// ------------------------------

// Counters wrap at this width
`define REFILL_CNT_W 16

`endif

// File: source/refill_fill_writer.sv
// Fill port holds data only while fill_valid_o is high; counters wrap silently at 16 bits
module refill_fill_writer (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Completed line from the buffer
    input  logic                    line_done_i,
    input  refill_pkg::line_t       line_data_i,
    input  logic                    line_l2_hit_i,

    // Held miss address from the requester
    input  refill_pkg::block_addr_t block_addr_i,

    // Cache fill port
    output logic                    fill_valid_o,
    output refill_pkg::block_addr_t fill_block_addr_o,
    output refill_pkg::line_t       fill_line_o,

    // Performance counters
    output refill_pkg::pmu_cnt_t    refill_count_o,
    output refill_pkg::pmu_cnt_t    l2_hit_count_o
);

    import refill_pkg::*;

    // ------------------------------
    // Fill port registers
    // ------------------------------

    logic        fill_valid_q;

    // Payload valid only with fill_valid_q
    block_addr_t fill_addr_q;
    line_t       fill_line_q;

    // Counters
    pmu_cnt_t    refill_cnt_q;
    pmu_cnt_t    hit_cnt_q;

    // Strobe and counters update together
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fill_valid_q <= 1'b0;
            refill_cnt_q <= '0;
            hit_cnt_q    <= '0;
        end else begin
            // One-cycle fill per completed line
            fill_valid_q <= line_done_i;
            if (line_done_i) begin
                refill_cnt_q <= refill_cnt_q + pmu_cnt_t'(1);
                // Hit counter only for refills served by L2
                if (line_l2_hit_i) begin
                    hit_cnt_q <= hit_cnt_q + pmu_cnt_t'(1);
                end
            end
        end
    end

    // Line and address captured with the pulse
    always_ff @(posedge clk_i) begin
        if (line_done_i) begin
            fill_addr_q <= block_addr_i;
            fill_line_q <= line_data_i;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign fill_valid_o      = fill_valid_q;
    assign fill_block_addr_o = fill_addr_q;
    assign fill_line_o       = fill_line_q;

    assign refill_count_o    = refill_cnt_q;
    assign l2_hit_count_o    = hit_cnt_q;

endmodule

// File: source/refill_pkg.sv
// Types of the refill path; needs refill_defines.svh on the include path
`include "refill_defines.svh"

package refill_pkg;

    // ------------------------------
    // Requester FSM
    // ------------------------------

    // Idle until a miss, then wait for the last grant beat
    typedef enum logic {
        REFILL_IDLE = 1'b0,
        REFILL_WAIT = 1'b1
    } refill_state_e;

    // ------------------------------
    // Payload types
    // ------------------------------

    // Block address of the missing line
    typedef logic [`REFILL_BLOCK_ADDR_W-1:0] block_addr_t;

    // Single grant beat from L2
    typedef logic [`REFILL_BEAT_W-1:0] beat_data_t;

    // Beat position inside the line
    typedef logic [`REFILL_BEAT_IDX_W-1:0] beat_idx_t;

    // Whole line with beat 0 in the low bits
    typedef logic [`REFILL_LINE_W-1:0] line_t;

    // Performance counter value
    typedef logic [`REFILL_CNT_W-1:0] pmu_cnt_t;

endpackage

// File: source/refill_requester.sv
// One miss outstanding at a time; a miss strobe seen while busy is dropped, not queued
module refill_requester (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Miss request from the icache
    input  logic                   miss_valid_i,
    input  refill_pkg::block_addr_t miss_block_addr_i,

    // Refill finished, from the line buffer
    input  logic                   line_done_i,

    // Acquire towards L2
    output logic                   acquire_valid_o,
    output refill_pkg::block_addr_t acquire_block_addr_o,

    // High while a miss is outstanding
    output logic                   miss_busy_o
);

    import refill_pkg::*;

    // ------------------------------
    // State and held address
    // ------------------------------

    refill_state_e state_q;
    refill_state_e state_d;

    // Address of the outstanding miss for the acquire and the fill writer
    block_addr_t   addr_q;

    // Single-cycle acquire strobe
    logic          acquire_q;

    // Miss accepted only from idle
    logic          accept;

    assign accept = miss_valid_i && (state_q == REFILL_IDLE);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            REFILL_IDLE: begin
                // New miss opens a refill
                if (miss_valid_i) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                // Last beat seen by the buffer closes it
                if (line_done_i) begin
                    state_d = REFILL_IDLE;
                end
            end
            default: begin
                state_d = REFILL_IDLE;
            end
        endcase
    end

    // Control registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= REFILL_IDLE;
            acquire_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            // One acquire per accepted miss
            acquire_q <= accept;
        end
    end

    // Address capture on an accepted miss
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= miss_block_addr_i;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign acquire_valid_o      = acquire_q;

    // Held for the whole refill
    assign acquire_block_addr_o = addr_q;

    // Busy rises with the acquire, falls after line_done
    assign miss_busy_o          = (state_q == REFILL_WAIT);

endmodule

// File: src.f
+incdir+source
source/refill_pkg.sv
source/refill_requester.sv
source/grant_line_buffer.sv
source/refill_fill_writer.sv
source/icache_refill_tile.sv
tests/tb_icache_refill_tile.sv

// File: tests/tb_icache_refill_tile.sv
// Drives beats 0..3 in order per refill with gaps of up to 2 cycles; checks run at the falling edge
`include "refill_defines.svh"

module tb_icache_refill_tile;

    import refill_pkg::*;

    // Covers 12 refills of at most 20 cycles plus margin
    localparam int MAX_CYCLES = 400;
    localparam int N_REFILLS  = 12;

    logic        clk_i;
    logic        rst_i;
    logic        miss_valid_i;
    block_addr_t miss_block_addr_i;
    logic        grant_valid_i;
    beat_idx_t   grant_beat_i;
    beat_data_t  grant_data_i;
    logic        l2_hit_i;
    logic        acquire_valid_o;
    block_addr_t acquire_block_addr_o;
    logic        miss_busy_o;
    logic        fill_valid_o;
    block_addr_t fill_block_addr_o;
    line_t       fill_line_o;
    pmu_cnt_t    refill_count_o;
    pmu_cnt_t    l2_hit_count_o;

    // Model of the expected outputs for the current cycle
    logic        exp_acq;
    logic        exp_busy;
    logic        exp_done;
    logic        exp_hit;
    logic        exp_fill_valid;
    block_addr_t exp_held;
    block_addr_t exp_fill_addr;
    line_t       exp_line;
    line_t       exp_fill_line;
    pmu_cnt_t    exp_refills;
    pmu_cnt_t    exp_hits;

    string       test_name;
    logic [31:0] rng;
    int          cycle_count;
    int          fills_seen;
    int          refills_sent;
    int          hits_sent;

    icache_refill_tile uut (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .miss_valid_i         (miss_valid_i),
        .miss_block_addr_i    (miss_block_addr_i),
        .grant_valid_i        (grant_valid_i),
        .grant_beat_i         (grant_beat_i),
        .grant_data_i         (grant_data_i),
        .l2_hit_i             (l2_hit_i),
        .acquire_valid_o      (acquire_valid_o),
        .acquire_block_addr_o (acquire_block_addr_o),
        .miss_busy_o          (miss_busy_o),
        .fill_valid_o         (fill_valid_o),
        .fill_block_addr_o    (fill_block_addr_o),
        .fill_line_o          (fill_line_o),
        .refill_count_o       (refill_count_o),
        .l2_hit_count_o       (l2_hit_count_o)
    );

    // 8 unit period
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [511:0] expected,
                                   input logic [511:0] actual);
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        abort_run();
    endtask

    // Inputs change 1 unit after the rising edge
    task automatic wait_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic issue_miss(input block_addr_t addr);
        miss_valid_i      = 1'b1;
        miss_block_addr_i = addr;
        wait_cycle();
        miss_valid_i      = 1'b0;
    endtask

    // Beats in order with random gaps and a stray miss on beat stray_beat
    task automatic send_line(input logic hit, input int stray_beat);
        logic [31:0] gap;
        for (int k = 0; k < `REFILL_BEATS; k++) begin
            rng = xorshift32(rng);
            gap = rng % 3;
            repeat (gap) wait_cycle();
            for (int j = 0; j < `REFILL_BEAT_W / 32; j++) begin
                rng = xorshift32(rng);
                grant_data_i[j*32 +: 32] = rng;
            end
            rng = xorshift32(rng);
            grant_valid_i = 1'b1;
            grant_beat_i  = beat_idx_t'(k);
            // Random hit noise on beats that do not end the line
            l2_hit_i      = (k == `REFILL_BEATS - 1) ? hit : rng[7];
            if (k == stray_beat) begin
                miss_valid_i      = 1'b1;
                miss_block_addr_i = block_addr_t'(rng >> 3);
            end
            wait_cycle();
            grant_valid_i = 1'b0;
            miss_valid_i  = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (miss_busy_o) begin
            wait_cycle();
        end
    endtask

    // Next-cycle expectations from this cycle's inputs
    task automatic advance_model();
        logic accept;
        accept = miss_valid_i && !exp_busy;
        // Fill and counters one cycle after line_done
        exp_fill_valid = exp_done;
        if (exp_done) begin
            exp_fill_addr = exp_held;
            exp_fill_line = exp_line;
            exp_refills   = exp_refills + pmu_cnt_t'(1);
            if (exp_hit) begin
                exp_hits = exp_hits + pmu_cnt_t'(1);
            end
        end
        // Busy drops the cycle after line_done
        exp_busy = exp_busy ? !exp_done : miss_valid_i;
        exp_acq  = accept;
        if (accept) begin
            exp_held = miss_block_addr_i;
        end
        // Beat k into bits 128k up
        if (grant_valid_i) begin
            exp_line[int'(grant_beat_i)*`REFILL_BEAT_W +: `REFILL_BEAT_W] = grant_data_i;
        end
        exp_done = grant_valid_i && (grant_beat_i == 2'd3);
        if (exp_done) begin
            exp_hit = l2_hit_i;
        end
    endtask

    // ------------------------------
    // Checker
    // ------------------------------

    always @(negedge clk_i) begin
        if (rst_i) begin
            exp_acq        = 1'b0;
            exp_busy       = 1'b0;
            exp_done       = 1'b0;
            exp_hit        = 1'b0;
            exp_fill_valid = 1'b0;
            exp_refills    = '0;
            exp_hits       = '0;
        end else begin
            assert (acquire_valid_o === exp_acq)
                else report_mismatch("acquire_valid_o", exp_acq, acquire_valid_o);
            if (exp_acq) begin
                assert (acquire_block_addr_o === exp_held)
                    else report_mismatch("acquire_block_addr_o", exp_held, acquire_block_addr_o);
            end
            assert (miss_busy_o === exp_busy)
                else report_mismatch("miss_busy_o", exp_busy, miss_busy_o);
            assert (fill_valid_o === exp_fill_valid)
                else report_mismatch("fill_valid_o", exp_fill_valid, fill_valid_o);
            if (exp_fill_valid) begin
                assert (fill_block_addr_o === exp_fill_addr)
                    else report_mismatch("fill_block_addr_o", exp_fill_addr, fill_block_addr_o);
                assert (fill_line_o === exp_fill_line)
                    else report_mismatch("fill_line_o", exp_fill_line, fill_line_o);
            end
            // Fill pulses as seen on the DUT port
            if (fill_valid_o === 1'b1) begin
                fills_seen++;
            end
            assert (refill_count_o === exp_refills)
                else report_mismatch("refill_count_o", exp_refills, refill_count_o);
            assert (l2_hit_count_o === exp_hits)
                else report_mismatch("l2_hit_count_o", exp_hits, l2_hit_count_o);
            advance_model();
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout in %s after %0d cycles, the refill did not finish",
                     test_name, cycle_count);
            abort_run();
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        rst_i             = 1'b1;
        miss_valid_i      = 1'b0;
        miss_block_addr_i = '0;
        grant_valid_i     = 1'b0;
        grant_beat_i      = '0;
        grant_data_i      = '0;
        l2_hit_i          = 1'b0;
        rng               = 32'd17;
        cycle_count       = 0;
        fills_seen        = 0;
        refills_sent      = 0;
        hits_sent         = 0;
        test_name         = "reset";
        repeat (3) wait_cycle();
        rst_i = 1'b0;

        // Outputs quiet straight after reset
        assert (!acquire_valid_o && !miss_busy_o && !fill_valid_o)
            else report_mismatch("control outputs", 0, {acquire_valid_o, miss_busy_o, fill_valid_o});
        assert (refill_count_o === '0 && l2_hit_count_o === '0)
            else report_mismatch("counters", 0, {refill_count_o, l2_hit_count_o});
        repeat (2) wait_cycle();

        for (int i = 0; i < N_REFILLS; i++) begin
            // Refill 4 also gets a stray miss while busy
            test_name = (i == 4) ? "busy_drop" : "refill";
            rng = xorshift32(rng);
            issue_miss(block_addr_t'(rng));
            rng = xorshift32(rng);
            hits_sent += rng[0];
            send_line(rng[0], (i == 4) ? 1 : `REFILL_BEATS);
            refills_sent++;
            wait_idle();
        end

        test_name = "counters";
        repeat (2) wait_cycle();
        assert (fills_seen == refills_sent)
            else report_mismatch("fill pulses", refills_sent, fills_seen);
        assert (refill_count_o === pmu_cnt_t'(refills_sent))
            else report_mismatch("refill_count_o", refills_sent, refill_count_o);
        assert (l2_hit_count_o === pmu_cnt_t'(hits_sent))
            else report_mismatch("l2_hit_count_o", hits_sent, l2_hit_count_o);

        $display("all tests passed");
        $finish;
    end

endmodule
